//--- logic/bus_controller.sv
/* CPU and memory bus controller: address latch, region decode, bank register,
   chip selects, read and write strobes, data steering */
`default_nettype none

module bus_controller #(
    parameter nora_pkg::bank_t RAMBANK_MASK = 8'h7F     // Usable banks after reset
) (
    input  wire logic                   clk6x,
    input  wire logic                   rst_n_i,
    input  wire nora_pkg::bus_strobe_s  strobe_i,       // From phaser
    // CPU side
    input  wire nora_pkg::cpu_addr_t    cpu_addr_i,
    input  wire logic                   cpu_rwn_i,
    input  wire nora_pkg::byte_t        cpu_db_i,
    output nora_pkg::byte_t             cpu_db_o,
    output logic                        cpu_db_oe_o,
    // Memory side
    input  wire nora_pkg::byte_t        mem_db_i,
    output nora_pkg::byte_t             mem_db_o,
    output logic                        mem_db_oe_o,
    output nora_pkg::mem_addr_hi_t      mem_abh_o,
    output logic                        sram_csn_o,
    output logic                        mem_rdn_o,
    output logic                        mem_wrn_o,
    output logic                        vera_csn_o,
    output logic                        aura_csn_o,
    output logic                        enet_csn_o,
    // Internal slave bus
    output nora_pkg::slv_bus_s          slv_o,
    input  wire nora_pkg::byte_t        slv_datard_i
);
    import nora_pkg::*;

    // One bit per device, at most one set
    typedef struct packed {
        logic sram;
        logic via;
        logic vera;
        logic aura;
        logic enet;
    } sel_s;

    sel_s         sel_d;
    sel_s         sel_q;
    mem_addr_hi_t abh_d;
    mem_addr_hi_t abh_q;
    cpu_addr_t    addr_q;       // Latched CPU address
    logic         rwn_q;
    logic         rdn_q;
    logic         wrn_q;
    bank_t        bank_q;
    logic [20:0]  bank_addr;    // Byte address inside the banked window
    logic [20:0]  top_addr;     // Byte address inside upper RAM

    // Region decode on the live CPU address, sampled at setup_cs
    always_comb
    begin
        sel_d     = '0;
        abh_d     = mem_addr_hi_t'(cpu_addr_i[15:12]);  // Low RAM maps 1:1
        bank_addr = BANK_MEM_BASE + 21'(bank_q) * BANK_SIZE + 21'(cpu_addr_i[12:0]);
        top_addr  = TOP_MEM_BASE + 21'(cpu_addr_i - HIMEM_BASE);
        if ((cpu_addr_i >= IO_BASE) && (cpu_addr_i <= IO_LAST))
        begin
            // I/O page, never SRAM
            sel_d.via  = (cpu_addr_i[15:4] == VIA1_BASE[15:4]);
            sel_d.vera = (cpu_addr_i[15:5] == VERA_BASE[15:5]);
            sel_d.aura = (cpu_addr_i[15:5] == AURA_BASE[15:5]);
            sel_d.enet = (cpu_addr_i[15:5] == ENET_BASE[15:5]);
        end
        else
        begin
            sel_d.sram = 1'b1;
            if ((cpu_addr_i >= BANK_WIN_BASE) && (cpu_addr_i <= BANK_WIN_LAST))
            begin
                abh_d = bank_addr[20:12];               // Window follows bank reg
            end
            else if (cpu_addr_i >= HIMEM_BASE)
            begin
                abh_d = top_addr[20:12];
            end
        end
    end

    // Address and direction of the current cycle
    always_ff @(posedge clk6x)
    begin
        if (strobe_i.setup_cs)
        begin
            addr_q <= cpu_addr_i;
            rwn_q  <= cpu_rwn_i;
            abh_q  <= abh_d;        // Goes out together with the selects
        end
    end

    // Selects and strobes
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            sel_q <= '0;
            rdn_q <= 1'b1;
            wrn_q <= 1'b1;
        end
        else
        begin
            if (strobe_i.setup_cs)
            begin
                sel_q <= sel_d;
                rdn_q <= !cpu_rwn_i;    // Low for reads
                wrn_q <= cpu_rwn_i;     // Low for writes
            end
            else if (strobe_i.release_cs)
            begin
                sel_q <= '0;
                rdn_q <= 1'b1;
            end
            if (strobe_i.release_wr)
            begin
                wrn_q <= 1'b1;          // Hold time before CS goes away
            end
        end
    end

    // Bank register, write through to SRAM as well
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            bank_q <= '0;
        end
        else if (strobe_i.release_wr && sel_q.sram && !rwn_q && (addr_q == BANKREG_ADDR))
        begin
            bank_q <= cpu_db_i & RAMBANK_MASK;
        end
    end

    assign sram_csn_o = !sel_q.sram;
    assign vera_csn_o = !sel_q.vera;
    assign aura_csn_o = !sel_q.aura;
    assign enet_csn_o = !sel_q.enet;
    assign mem_rdn_o  = rdn_q;
    assign mem_wrn_o  = wrn_q;
    assign mem_abh_o  = abh_q;

    // Slave bus to the VIA
    assign slv_o.regidx       = addr_q[3:0];
    assign slv_o.datawr       = cpu_db_i;           // CPU data valid late in the cycle
    assign slv_o.datawr_valid = sel_q.via && !rwn_q && strobe_i.release_wr;
    assign slv_o.req          = sel_q.via;
    assign slv_o.rwn          = rwn_q;

    // Data steering
    assign cpu_db_o    = sel_q.via ? slv_datard_i : mem_db_i;
    assign cpu_db_oe_o = cpu_rwn_i;                 // Off while the CPU drives write data
    assign mem_db_o    = cpu_db_i;
    assign mem_db_oe_o = mem_rdn_o;                 // Off while the SRAM drives read data

endmodule

`default_nettype wire

//--- logic/cpu_phaser.sv
/* CPU clock phaser, six clocks per CPU cycle, phi2 and bus timing strobes */
`default_nettype none

module cpu_phaser (
    input  wire logic                  clk6x,
    input  wire logic                  rst_n_i,
    output logic                       phi2_o,      // CPU clock
    output nora_pkg::bus_strobe_s      strobe_o     // Setup and release pulses
);
    import nora_pkg::*;

    phase_t phase_q;
    phase_t phase_d;
    logic   phi2_q;

    // Next phase, wraps after PH_5
    always_comb
    begin
        case (phase_q)
            PH_0:    phase_d = PH_1;
            PH_1:    phase_d = PH_2;
            PH_2:    phase_d = PH_3;
            PH_3:    phase_d = PH_4;
            PH_4:    phase_d = PH_5;
            default: phase_d = PH_0;
        endcase
    end

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            phase_q <= PH_0;
            phi2_q  <= 1'b0;
        end
        else
        begin
            phase_q <= phase_d;
            // High while the next phase is PH_3..PH_5
            phi2_q  <= (phase_d == PH_3) || (phase_d == PH_4) || (phase_d == PH_5);
        end
    end

    assign phi2_o = phi2_q;

    // Strobes straight from the phase
    assign strobe_o.setup_cs   = (phase_q == PH_2);     // Address is stable by now
    assign strobe_o.release_wr = (phase_q == PH_4);     // Write ends one clock before CS
    assign strobe_o.release_cs = (phase_q == PH_5);     // End of access

endmodule

`default_nettype wire

//--- logic/nora_pkg.sv
/* Shared types, phaser states, address map and block-to-block structs
   for the NORA system controller */
`default_nettype none

package nora_pkg;

    typedef logic [7:0]  byte_t;            // Data byte
    typedef logic [15:0] cpu_addr_t;        // CPU address
    typedef logic [8:0]  mem_addr_hi_t;     // SRAM address bits 20..12
    typedef logic [7:0]  bank_t;            // RAM bank number
    typedef logic [3:0]  via_reg_t;         // VIA register index

    // Six clocks per CPU cycle
    typedef enum logic [2:0] {
        PH_0 = 3'd0,
        PH_1 = 3'd1,
        PH_2 = 3'd2,
        PH_3 = 3'd3,
        PH_4 = 3'd4,
        PH_5 = 3'd5
    } phase_t;

    // CPU address map
    localparam cpu_addr_t IO_BASE       = 16'h9F00;
    localparam cpu_addr_t IO_LAST       = 16'h9FFF;
    localparam cpu_addr_t VIA1_BASE     = 16'h9F00;   // 16 byte window
    localparam cpu_addr_t VERA_BASE     = 16'h9F20;   // 32 byte windows from here
    localparam cpu_addr_t AURA_BASE     = 16'h9F40;
    localparam cpu_addr_t ENET_BASE     = 16'h9F60;
    localparam cpu_addr_t BANK_WIN_BASE = 16'hA000;
    localparam cpu_addr_t BANK_WIN_LAST = 16'hBFFF;
    localparam cpu_addr_t BANKREG_ADDR  = 16'h0000;
    localparam cpu_addr_t HIMEM_BASE    = 16'hC000;

    // SRAM side, full 21 bit byte addresses
    localparam logic [20:0] BANK_MEM_BASE = 21'h01_0000;
    localparam logic [20:0] BANK_SIZE     = 21'h00_2000;   // 8 KB
    localparam logic [20:0] TOP_MEM_BASE  = 21'h1F_C000;   // Upper RAM lands at the very top

    // Bus timing pulses, one clock each
    typedef struct packed {
        logic setup_cs;     // PH_2
        logic release_wr;   // PH_4
        logic release_cs;   // PH_5
    } bus_strobe_s;

    // Internal slave bus
    typedef struct packed {
        via_reg_t regidx;
        byte_t    datawr;
        logic     datawr_valid;   // Single pulse at release_wr
        logic     req;            // Level, PH_3..PH_5
        logic     rwn;
    } slv_bus_s;

    typedef struct packed {
        byte_t ora;
        byte_t orb;
        byte_t ddra;    // 1 = output
        byte_t ddrb;
    } via_port_s;

endpackage

`default_nettype wire

//--- logic/nora_top.sv
/* NORA top level: phaser, bus controller, VIA1 and its pin mapping */
`default_nettype none

module nora_top #(
    parameter nora_pkg::bank_t RAMBANK_MASK = 8'h7F,       // 128 banks after reset
    parameter int unsigned     BLINK_TOP    = 32'd4194304
) (
    input  wire logic                   clk6x,
    input  wire logic                   rst_n_i,
    // CPU bus
    input  wire nora_pkg::cpu_addr_t    cpu_addr_i,
    input  wire logic                   cpu_rwn_i,
    input  wire nora_pkg::byte_t        cpu_db_i,
    output nora_pkg::byte_t             cpu_db_o,
    output logic                        cpu_db_oe_o,
    output logic                        cpu_phi2_o,
    output logic                        cpu_irqn_o,
    input  wire logic                   virqn_i,        // Wired-OR IRQ from VERA side
    // Memory bus
    input  wire nora_pkg::byte_t        mem_db_i,
    output nora_pkg::byte_t             mem_db_o,
    output logic                        mem_db_oe_o,
    output nora_pkg::mem_addr_hi_t      mem_abh_o,
    output logic                        sram_csn_o,
    output logic                        mem_rdn_o,
    output logic                        mem_wrn_o,
    output logic                        vera_csn_o,
    output logic                        aura_csn_o,
    output logic                        enet_csn_o,
    // GPIO pins
    output logic                        nes_latch_o,
    output logic                        nes_clock_o,
    input  wire logic                   nes_data0_i,
    input  wire logic                   nes_data1_i,
    input  wire logic                   i2c_scl_i,
    output logic                        i2c_scl_o,
    output logic                        i2c_scl_oe_o,
    input  wire logic                   i2c_sda_i,
    output logic                        i2c_sda_drlow_o,
    output logic                        cpu_led0_o,
    output logic                        cpu_led1_o
);
    import nora_pkg::*;

    bus_strobe_s strobe;
    slv_bus_s    slv;
    byte_t       via_datard;
    via_port_s   via_port;
    byte_t       via_ira;
    byte_t       via_irb;

    cpu_phaser phaser_i (
        .clk6x    (clk6x),
        .rst_n_i  (rst_n_i),
        .phi2_o   (cpu_phi2_o),
        .strobe_o (strobe)
    );

    bus_controller #(
        .RAMBANK_MASK (RAMBANK_MASK)
    ) busctrl_i (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .strobe_i     (strobe),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_rwn_i    (cpu_rwn_i),
        .cpu_db_i     (cpu_db_i),
        .cpu_db_o     (cpu_db_o),
        .cpu_db_oe_o  (cpu_db_oe_o),
        .mem_db_i     (mem_db_i),
        .mem_db_o     (mem_db_o),
        .mem_db_oe_o  (mem_db_oe_o),
        .mem_abh_o    (mem_abh_o),
        .sram_csn_o   (sram_csn_o),
        .mem_rdn_o    (mem_rdn_o),
        .mem_wrn_o    (mem_wrn_o),
        .vera_csn_o   (vera_csn_o),
        .aura_csn_o   (aura_csn_o),
        .enet_csn_o   (enet_csn_o),
        .slv_o        (slv),
        .slv_datard_i (via_datard)
    );

    simple_via via1_i (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .slv_i        (slv),
        .ira_i        (via_ira),
        .irb_i        (via_irb),
        .slv_datard_o (via_datard),
        .port_o       (via_port)
    );

    via_gpio_pins #(
        .BLINK_TOP (BLINK_TOP)
    ) pins_i (
        .clk6x           (clk6x),
        .rst_n_i         (rst_n_i),
        .port_i          (via_port),
        .nes_data0_i     (nes_data0_i),
        .nes_data1_i     (nes_data1_i),
        .i2c_scl_i       (i2c_scl_i),
        .i2c_sda_i       (i2c_sda_i),
        .ira_o           (via_ira),
        .irb_o           (via_irb),
        .nes_latch_o     (nes_latch_o),
        .nes_clock_o     (nes_clock_o),
        .i2c_scl_o       (i2c_scl_o),
        .i2c_scl_oe_o    (i2c_scl_oe_o),
        .i2c_sda_drlow_o (i2c_sda_drlow_o),
        .cpu_led0_o      (cpu_led0_o),
        .cpu_led1_o      (cpu_led1_o)
    );

    assign cpu_irqn_o = virqn_i;    // No local IRQ sources

endmodule

`default_nettype wire

//--- logic/simple_via.sv
/* Simplified 65C22, GPIO only: ORB, ORA, DDRB, DDRA and the ORA alias */
`default_nettype none

module simple_via (
    input  wire logic                  clk6x,
    input  wire logic                  rst_n_i,
    input  wire nora_pkg::slv_bus_s    slv_i,
    input  wire nora_pkg::byte_t       ira_i,          // Port A pin levels
    input  wire nora_pkg::byte_t       irb_i,          // Port B pin levels
    output nora_pkg::byte_t            slv_datard_o,
    output nora_pkg::via_port_s        port_o
);
    import nora_pkg::*;

    // Register indices
    localparam via_reg_t REG_ORB   = 4'd0;
    localparam via_reg_t REG_ORA   = 4'd1;
    localparam via_reg_t REG_DDRB  = 4'd2;
    localparam via_reg_t REG_DDRA  = 4'd3;
    localparam via_reg_t REG_ORA_NH = 4'd15;   // ORA without handshake

    via_port_s port_q;
    logic      wr_en;
    byte_t     porta_rd;
    byte_t     portb_rd;

    assign wr_en = slv_i.req && !slv_i.rwn && slv_i.datawr_valid;

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            port_q <= '0;                       // All pins inputs
        end
        else if (wr_en)
        begin
            case (slv_i.regidx)
                REG_ORB:    port_q.orb  <= slv_i.datawr;
                REG_ORA:    port_q.ora  <= slv_i.datawr;
                REG_DDRB:   port_q.ddrb <= slv_i.datawr;
                REG_DDRA:   port_q.ddra <= slv_i.datawr;
                REG_ORA_NH: port_q.ora  <= slv_i.datawr;
                default:    ;                   // Timers etc. not present
            endcase
        end
    end

    // Output bits where DDR is 1, pin level elsewhere
    assign porta_rd = (port_q.ora & port_q.ddra) | (ira_i & ~port_q.ddra);
    assign portb_rd = (port_q.orb & port_q.ddrb) | (irb_i & ~port_q.ddrb);

    always_comb
    begin
        case (slv_i.regidx)
            REG_ORB:    slv_datard_o = portb_rd;
            REG_ORA:    slv_datard_o = porta_rd;
            REG_DDRB:   slv_datard_o = port_q.ddrb;
            REG_DDRA:   slv_datard_o = port_q.ddra;
            REG_ORA_NH: slv_datard_o = porta_rd;
            default:    slv_datard_o = 8'h00;
        endcase
    end

    assign port_o = port_q;

endmodule

`default_nettype wire

//--- logic/via_gpio_pins.sv
/* VIA port to pin mapping for NES pad, I2C and CPU LEDs, with LED0 blinker */
`default_nettype none

module via_gpio_pins #(
    parameter int unsigned BLINK_TOP = 32'd4194304     // Blinker half period in clocks
) (
    input  wire logic                  clk6x,
    input  wire logic                  rst_n_i,
    input  wire nora_pkg::via_port_s   port_i,
    input  wire logic                  nes_data0_i,
    input  wire logic                  nes_data1_i,
    input  wire logic                  i2c_scl_i,
    input  wire logic                  i2c_sda_i,
    output nora_pkg::byte_t            ira_o,
    output nora_pkg::byte_t            irb_o,
    output logic                       nes_latch_o,
    output logic                       nes_clock_o,
    output logic                       i2c_scl_o,
    output logic                       i2c_scl_oe_o,
    output logic                       i2c_sda_drlow_o,    // Open drain pull
    output logic                       cpu_led0_o,
    output logic                       cpu_led1_o
);
    import nora_pkg::*;

    localparam int CNT_W = (BLINK_TOP > 1) ? $clog2(BLINK_TOP) : 1;

    logic [CNT_W-1:0] blink_cnt;
    logic             blink_q;

    // Free running blinker
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            blink_cnt <= '0;
            blink_q   <= 1'b0;
        end
        else if (blink_cnt == CNT_W'(BLINK_TOP - 1))
        begin
            blink_cnt <= '0;
            blink_q   <= !blink_q;
        end
        else
        begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    assign nes_clock_o     = port_i.ddra[3] ? port_i.ora[3] : 1'b0;
    assign nes_latch_o     = port_i.ddra[2] ? port_i.ora[2] : 1'b0;
    assign i2c_scl_o       = port_i.ora[1];
    assign i2c_scl_oe_o    = port_i.ddra[1];
    assign i2c_sda_drlow_o = port_i.ddra[0] && !port_i.ora[0];      // Never drive SDA high
    assign cpu_led0_o      = port_i.ddrb[0] ? port_i.orb[0] : blink_q;
    assign cpu_led1_o      = port_i.ddrb[1] ? port_i.orb[1] : 1'b1;

    // Pin levels as seen by the CPU
    assign ira_o = {nes_data0_i, nes_data1_i, 2'b11, nes_clock_o, nes_latch_o,
                    i2c_scl_i, i2c_sda_i};
    assign irb_o = {6'b110000, cpu_led1_o, cpu_led0_o};

endmodule

`default_nettype wire

//--- nora_top.f
logic/nora_pkg.sv
logic/cpu_phaser.sv
logic/bus_controller.sv
logic/simple_via.sv
logic/via_gpio_pins.sv
logic/nora_top.sv
sim/nora_tb_assert.sv
sim/nora_tb.sv

//--- sim/nora_tb.sv
/* Testbench for nora_top: clock, reset, CPU bus model with xorshift data,
   timeout and result report */
`default_nettype none

module nora_tb;
    import nora_pkg::*;

    localparam int DRIVE_DLY  = 2;      // After the rising edge
    localparam int N_RANDOM   = 60;
    localparam int N_CYCLES   = 18 + 12 + 40 + N_RANDOM + 2;
    localparam int CLK_LIMIT  = N_CYCLES * 6 + 200;

    logic         clk6x = 1'b0;
    logic         rst_n_i;
    cpu_addr_t    cpu_addr_i;
    logic         cpu_rwn_i;
    byte_t        cpu_db_i;
    byte_t        cpu_db_o;
    logic         cpu_db_oe_o;
    logic         cpu_phi2_o;
    logic         cpu_irqn_o;
    logic         virqn_i;
    byte_t        mem_db_i;
    byte_t        mem_db_o;
    logic         mem_db_oe_o;
    mem_addr_hi_t mem_abh_o;
    logic         sram_csn_o;
    logic         mem_rdn_o;
    logic         mem_wrn_o;
    logic         vera_csn_o;
    logic         aura_csn_o;
    logic         enet_csn_o;
    logic         nes_latch_o;
    logic         nes_clock_o;
    logic         nes_data0_i;
    logic         nes_data1_i;
    logic         i2c_scl_i;
    logic         i2c_scl_o;
    logic         i2c_scl_oe_o;
    logic         i2c_sda_i;
    logic         i2c_sda_drlow_o;
    logic         cpu_led0_o;
    logic         cpu_led1_o;

    logic [31:0]  rng = 32'h22a6_9b46;
    int           clk_cnt = 0;
    int           errors;
    // Edges of every region plus the bank register address
    cpu_addr_t    corners [18] = '{16'h0000, 16'h9EFF, 16'h9F00, 16'h9F0F, 16'h9F10, 16'h9F1F,
                                   16'h9F20, 16'h9F3F, 16'h9F40, 16'h9F5F, 16'h9F60, 16'h9F7F,
                                   16'h9F80, 16'h9FFF, 16'hA000, 16'hBFFF, 16'hC000, 16'hFFFF};
    via_reg_t     via_rd_idx [6] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd15, 4'd5};

    nora_top #(.BLINK_TOP(40)) nora_top_i (.*);

    bind nora_top nora_tb_assert #(.RAMBANK_MASK(RAMBANK_MASK), .BLINK_TOP(BLINK_TOP))
        chk_i (.*);

    always #10 clk6x = ~clk6x;      // 20 per period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One CPU cycle, driven in PH_1 after the phi2 fall
    task automatic cpu_access(input cpu_addr_t addr, input logic rwn, input byte_t data);
        @(negedge cpu_phi2_o);
        @(posedge clk6x);
        #DRIVE_DLY;
        cpu_addr_i = addr;
        cpu_rwn_i  = rwn;
        cpu_db_i   = data;
        if (rwn)
        begin
            rng      = xorshift32(rng);
            mem_db_i = rng[7:0];        // SRAM read data
        end
    endtask

    always @(posedge clk6x)
    begin
        clk_cnt = clk_cnt + 1;
        if (clk_cnt >= CLK_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d clocks", CLK_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        rst_n_i     = 1'b0;
        cpu_addr_i  = 16'hFFFC;         // Harmless read of upper RAM
        cpu_rwn_i   = 1'b1;
        cpu_db_i    = 8'h00;
        mem_db_i    = 8'h00;
        virqn_i     = 1'b1;
        nes_data0_i = 1'b1;
        nes_data1_i = 1'b1;
        i2c_scl_i   = 1'b1;
        i2c_sda_i   = 1'b1;
        repeat (16) @(posedge clk6x);
        #DRIVE_DLY rst_n_i = 1'b1;

        foreach (corners[i])
            cpu_access(corners[i], 1'b1, 8'h00);

        // Bank register, then both ends of the window
        repeat (4)
        begin
            rng = xorshift32(rng);
            cpu_access(BANKREG_ADDR, 1'b0, rng[7:0]);
            cpu_access(BANK_WIN_BASE + cpu_addr_t'(rng[20:8]), 1'b1, 8'h00);
            cpu_access(BANK_WIN_LAST, 1'b0, rng[31:24]);
        end

        // VIA setup with random pins, then read back
        repeat (4)
        begin
            rng = xorshift32(rng);
            {nes_data0_i, nes_data1_i, i2c_scl_i, i2c_sda_i} = rng[3:0];
            rng = xorshift32(rng);
            cpu_access(VIA1_BASE + 16'd3, 1'b0, rng[7:0]);
            cpu_access(VIA1_BASE + 16'd1, 1'b0, rng[15:8]);
            cpu_access(VIA1_BASE + 16'd2, 1'b0, rng[23:16]);
            cpu_access(VIA1_BASE + 16'd0, 1'b0, rng[31:24]);
            foreach (via_rd_idx[i])
                cpu_access(VIA1_BASE + cpu_addr_t'(via_rd_idx[i]), 1'b1, 8'h00);
        end

        repeat (N_RANDOM)
        begin
            rng = xorshift32(rng);
            virqn_i = rng[17];          // IRQ line wiggles with the traffic
            cpu_access(rng[15:0], rng[16], rng[31:24]);
        end

        // Let the last access complete
        @(negedge cpu_phi2_o);
        @(posedge clk6x);
        #DRIVE_DLY;
        errors = nora_top_i.chk_i.fail_cnt;
        $display("Run complete, %0d assertion failures", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/nora_tb_assert.sv
/* Bus timing, region decode, bank, VIA and pin assertions with reference
   models of the bank register and VIA registers, bound to nora_top */
`default_nettype none

module nora_tb_assert #(
    parameter nora_pkg::bank_t RAMBANK_MASK = 8'h7F,
    parameter int unsigned     BLINK_TOP    = 32'd4194304
) (
    input wire logic                  clk6x,
    input wire logic                  rst_n_i,
    input wire nora_pkg::cpu_addr_t   cpu_addr_i,
    input wire logic                  cpu_rwn_i,
    input wire nora_pkg::byte_t       cpu_db_i,
    input wire nora_pkg::byte_t       cpu_db_o,
    input wire logic                  cpu_db_oe_o,
    input wire logic                  cpu_phi2_o,
    input wire logic                  cpu_irqn_o,
    input wire logic                  virqn_i,
    input wire nora_pkg::byte_t       mem_db_i,
    input wire nora_pkg::byte_t       mem_db_o,
    input wire logic                  mem_db_oe_o,
    input wire nora_pkg::mem_addr_hi_t mem_abh_o,
    input wire logic                  sram_csn_o,
    input wire logic                  mem_rdn_o,
    input wire logic                  mem_wrn_o,
    input wire logic                  vera_csn_o,
    input wire logic                  aura_csn_o,
    input wire logic                  enet_csn_o,
    input wire logic                  nes_latch_o,
    input wire logic                  nes_clock_o,
    input wire logic                  nes_data0_i,
    input wire logic                  nes_data1_i,
    input wire logic                  i2c_scl_i,
    input wire logic                  i2c_scl_o,
    input wire logic                  i2c_scl_oe_o,
    input wire logic                  i2c_sda_i,
    input wire logic                  i2c_sda_drlow_o,
    input wire logic                  cpu_led0_o,
    input wire logic                  cpu_led1_o
);
    import nora_pkg::*;

    typedef struct packed {
        logic sram;
        logic via;
        logic vera;
        logic aura;
        logic enet;
    } region_s;

    int           fail_cnt = 0;     // Read by the testbench at the end
    logic [2:0]   ref_phase;        // 0..5, PH_3..PH_5 is the access
    int unsigned  edge_cnt;         // Clocks since reset release
    cpu_addr_t    lat_addr;
    logic         lat_rwn;
    mem_addr_hi_t exp_abh;
    bank_t        ref_bank;
    via_port_s    ref_port;
    region_s      exp_sel;
    logic         in_acc;
    logic         blink_ref;
    logic         exp_led0;
    logic         exp_led1;
    byte_t        exp_ira;
    byte_t        exp_irb;
    byte_t        exp_via_rd;

    // Region from the CPU address map
    function automatic region_s decode_region(input cpu_addr_t addr);
        region_s r;
        r = '0;
        if ((addr >= IO_BASE) && (addr <= IO_LAST))
        begin
            r.via  = (addr < VIA1_BASE + 16'd16);
            r.vera = (addr >= VERA_BASE) && (addr < VERA_BASE + 16'd32);
            r.aura = (addr >= AURA_BASE) && (addr < AURA_BASE + 16'd32);
            r.enet = (addr >= ENET_BASE) && (addr < ENET_BASE + 16'd32);
        end
        else
        begin
            r.sram = 1'b1;      // Everything outside I/O is RAM
        end
        return r;
    endfunction

    // SRAM 4 KB page for a CPU address
    function automatic mem_addr_hi_t sram_page(input cpu_addr_t addr, input bank_t bank);
        logic [20:0] byte_addr;
        if ((addr >= BANK_WIN_BASE) && (addr <= BANK_WIN_LAST))
            byte_addr = BANK_MEM_BASE + BANK_SIZE * bank + (addr - BANK_WIN_BASE);
        else if (addr >= HIMEM_BASE)
            byte_addr = TOP_MEM_BASE + (addr - HIMEM_BASE);
        else
            byte_addr = {5'd0, addr};   // Low RAM 1:1
        return byte_addr[20:12];
    endfunction

    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ref_phase <= 3'd0;
            edge_cnt  <= 0;
            lat_addr  <= '0;
            lat_rwn   <= 1'b1;
            exp_abh   <= '0;
            ref_bank  <= '0;
            ref_port  <= '0;
        end
        else
        begin
            ref_phase <= (ref_phase == 3'd5) ? 3'd0 : ref_phase + 3'd1;
            edge_cnt  <= edge_cnt + 1;
            if (ref_phase == 3'd2)              // Address setup point
            begin
                lat_addr <= cpu_addr_i;
                lat_rwn  <= cpu_rwn_i;
                exp_abh  <= sram_page(cpu_addr_i, ref_bank);
            end
            if ((ref_phase == 3'd4) && !lat_rwn) // Write commit point
            begin
                if (lat_addr == BANKREG_ADDR)
                    ref_bank <= cpu_db_i & RAMBANK_MASK;
                if (exp_sel.via)
                begin
                    case (lat_addr[3:0])
                        4'd0:    ref_port.orb  <= cpu_db_i;
                        4'd1:    ref_port.ora  <= cpu_db_i;
                        4'd2:    ref_port.ddrb <= cpu_db_i;
                        4'd3:    ref_port.ddra <= cpu_db_i;
                        4'd15:   ref_port.ora  <= cpu_db_i;   // ORA alias
                        default: ;
                    endcase
                end
            end
        end
    end

    assign exp_sel   = decode_region(lat_addr);
    assign in_acc    = (ref_phase >= 3'd3);
    assign blink_ref = ((edge_cnt / BLINK_TOP) % 2) == 1;
    assign exp_led0  = ref_port.ddrb[0] ? ref_port.orb[0] : blink_ref;
    assign exp_led1  = ref_port.ddrb[1] ? ref_port.orb[1] : 1'b1;
    assign exp_ira   = {nes_data0_i, nes_data1_i, 2'b11, ref_port.ddra[3] & ref_port.ora[3],
                        ref_port.ddra[2] & ref_port.ora[2], i2c_scl_i, i2c_sda_i};
    assign exp_irb   = {6'b110000, exp_led1, exp_led0};

    // Output bit where DDR set, pin level otherwise
    always_comb
    begin
        case (lat_addr[3:0])
            4'd0:    exp_via_rd = (ref_port.orb & ref_port.ddrb) | (exp_irb & ~ref_port.ddrb);
            4'd1:    exp_via_rd = (ref_port.ora & ref_port.ddra) | (exp_ira & ~ref_port.ddra);
            4'd2:    exp_via_rd = ref_port.ddrb;
            4'd3:    exp_via_rd = ref_port.ddra;
            4'd15:   exp_via_rd = (ref_port.ora & ref_port.ddra) | (exp_ira & ~ref_port.ddra);
            default: exp_via_rd = 8'h00;
        endcase
    end

    a_phi2: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        cpu_phi2_o == in_acc)
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t phi2 out of phase", $time);
        end

    a_sel: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        {sram_csn_o, vera_csn_o, aura_csn_o, enet_csn_o} ==
        (in_acc ? ~{exp_sel.sram, exp_sel.vera, exp_sel.aura, exp_sel.enet} : 4'hF))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t wrong select, addr %h", $time, lat_addr);
        end

    a_rdn: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        mem_rdn_o == !(in_acc && lat_rwn))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t mem_rdn_o span wrong", $time);
        end

    a_wrn: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        mem_wrn_o == !(((ref_phase == 3'd3) || (ref_phase == 3'd4)) && !lat_rwn))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t mem_wrn_o span wrong", $time);
        end

    a_abh: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        (in_acc && exp_sel.sram) |-> (mem_abh_o == exp_abh))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t abh %h, expected %h", $time, mem_abh_o, exp_abh);
        end

    a_rdata: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        (in_acc && lat_rwn && (exp_sel.via || exp_sel.sram)) |->
        (cpu_db_o == (exp_sel.via ? exp_via_rd : mem_db_i)))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t read data %h at addr %h", $time, cpu_db_o, lat_addr);
        end

    // Bus directions, write data and IRQ pass straight through
    a_dbus: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        (cpu_db_oe_o == cpu_rwn_i) && (mem_db_o == cpu_db_i) &&
        (mem_db_oe_o == !(in_acc && lat_rwn)) && (cpu_irqn_o == virqn_i))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t data bus enable, write data or IRQ wrong", $time);
        end

    a_pins: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        ({nes_clock_o, nes_latch_o} == (ref_port.ddra[3:2] & ref_port.ora[3:2])) &&
        (i2c_scl_oe_o == ref_port.ddra[1]) &&
        (!ref_port.ddra[1] || (i2c_scl_o == ref_port.ora[1])) &&
        (i2c_sda_drlow_o == (ref_port.ddra[0] && !ref_port.ora[0])))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t NES or I2C pin mismatch", $time);
        end

    a_leds: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        (cpu_led0_o == exp_led0) && (cpu_led1_o == exp_led1))
        else
        begin
            fail_cnt++;
            $error("[ERROR] %0t LED pins %b%b", $time, cpu_led1_o, cpu_led0_o);
        end

endmodule

`default_nettype wire
